// ==== src/invadersPkg.sv ====
`default_nettype none

package invadersPkg;

	// widths
	localparam int COORD_W = 10;
	localparam int SCORE_W = 6;
	localparam int COLOR_W = 8;

	////////////////////////////////////////////////////////////////////////////
	// raster, 640x480 active inside an 800x521 scan
	localparam logic [COORD_W-1:0] H_TOTAL = 10'd800;
	localparam logic [COORD_W-1:0] V_TOTAL = 10'd521;
	localparam logic [COORD_W-1:0] H_PULSE = 10'd96;
	localparam logic [COORD_W-1:0] V_PULSE = 10'd2;
	localparam logic [COORD_W-1:0] H_BACK = 10'd144;
	localparam logic [COORD_W-1:0] H_FRONT = 10'd784;
	localparam logic [COORD_W-1:0] V_BACK = 10'd31;
	localparam logic [COORD_W-1:0] V_FRONT = 10'd511;

	// side bars of the play field
	localparam logic [COORD_W-1:0] LEFT_BAR = 10'd344;
	localparam logic [COORD_W-1:0] RIGHT_BAR = 10'd584;

	////////////////////////////////////////////////////////////////////////////
	// player and bullet
	localparam logic [COORD_W-1:0] PLAYER_Y = 10'd441;
	localparam logic [COORD_W-1:0] PLAYER_START_X = 10'd464;
	localparam logic [COORD_W-1:0] PLAYER_W = 10'd18;
	localparam logic [COORD_W-1:0] PLAYER_H = 10'd7;
	localparam logic [COORD_W-1:0] MUZZLE_X = 10'd9;
	localparam logic [COORD_W-1:0] BULLET_W = 10'd2;
	localparam logic [COORD_W-1:0] BULLET_H = 10'd10;

	// alien formation, offsets indexed by alien number
	localparam int NUM_ALIENS = 5;
	localparam logic [COORD_W-1:0] FORM_START_X = 10'd344;
	localparam logic [COORD_W-1:0] FORM_START_Y = 10'd251;
	localparam logic [NUM_ALIENS-1:0][COORD_W-1:0] ALIEN_OFS_X =
		{10'd80, 10'd0, 10'd80, 10'd40, 10'd0};
	localparam logic [NUM_ALIENS-1:0][COORD_W-1:0] ALIEN_OFS_Y =
		{10'd30, 10'd30, 10'd0, 10'd0, 10'd0};
	localparam logic [COORD_W-1:0] ALIEN_W = 10'd11;
	localparam logic [COORD_W-1:0] ALIEN_H = 10'd7;
	localparam int STEP_TICKS = 4;
	localparam int MARCH_STEPS = 144;
	localparam logic [COORD_W-1:0] DROP_ROWS = 10'd10;
	localparam logic [COORD_W-1:0] HIT_DEPTH = 10'd8;
	localparam logic [SCORE_W-1:0] SCORE_PER_HIT = 6'd10;

	// colours, rrr_ggg_bb
	localparam logic [COLOR_W-1:0] COL_BLACK = 8'h00;
	localparam logic [COLOR_W-1:0] COL_RED = 8'hE0;
	localparam logic [COLOR_W-1:0] COL_BAR = 8'hE3;
	localparam logic [COLOR_W-1:0] COL_WHITE = 8'hFF;
	localparam logic [COLOR_W-1:0] COL_YELLOW = 8'hFC;
	localparam logic [COLOR_W-1:0] COL_GREEN = 8'h1C;

endpackage

`default_nettype wire

// ==== src/scanTiming.sv ====
`timescale 1ns/10ps
`default_nettype none

module scanTiming
	import invadersPkg::*;
(
	input wire clk,
	input wire spawnBullet,
	input wire pixelEn,
	output logic [COORD_W-1:0] hPos,
	output logic [COORD_W-1:0] vPos,
	output logic hsync,
	output logic vsync
);

	// pixel and line counters, one step per pixel strobe
	always_ff @(posedge clk or posedge spawnBullet)
	begin
		if (spawnBullet)
		begin
			hPos <= '0;
			vPos <= '0;
		end
		else if (pixelEn)
		begin
			if (hPos == H_TOTAL - 1'b1)
			begin
				hPos <= '0;
				// end of line, move to next line or wrap the frame
				if (vPos == V_TOTAL - 1'b1)
					vPos <= '0;
				else
					vPos <= vPos + 1'b1;
			end
			else
				hPos <= hPos + 1'b1;
		end
	end

	// active-low sync pulses at the start of line and frame
	assign hsync = (hPos >= H_PULSE);
	assign vsync = (vPos >= V_PULSE);

endmodule

`default_nettype wire

// ==== src/playerCannon.sv ====
`timescale 1ns/10ps
`default_nettype none

module playerCannon
	import invadersPkg::*;
(
	input wire clk,
	input wire spawnBullet,
	input wire gameTick,
	input wire btnFire,
	input wire btnLeft,
	input wire btnRight,
	input wire bulletHit,
	input wire aliensRemain,
	input wire gameOver,
	output logic [COORD_W-1:0] playerX,
	output logic [COORD_W-1:0] bulletX,
	output logic [COORD_W-1:0] bulletY,
	output logic bulletActive
);

	////////////////////////////////////////////////////////////////////////////
	// cannon position, clamped between the bars
	always_ff @(posedge clk or posedge spawnBullet)
	begin
		if (spawnBullet)
			playerX <= PLAYER_START_X;
		else if (gameTick && !gameOver)
		begin
			if (btnLeft && playerX != LEFT_BAR)
				playerX <= playerX - 1'b1;
			// right is evaluated last so it takes over when both are held
			if (btnRight && playerX != RIGHT_BAR - PLAYER_W)
				playerX <= playerX + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// single bullet, spawned at the muzzle and rising one row per tick
	always_ff @(posedge clk or posedge spawnBullet)
	begin
		if (spawnBullet)
		begin
			bulletActive <= 1'b0;
			bulletX <= '0;
			bulletY <= '0;
		end
		else if (gameTick && !gameOver)
		begin
			if (bulletHit)
				bulletActive <= 1'b0;
			else if (bulletActive)
			begin
				bulletY <= bulletY - 1'b1;
				// top of the screen reached
				if (bulletY - 1'b1 <= V_BACK)
					bulletActive <= 1'b0;
			end
			else if (btnFire && aliensRemain)
			begin
				bulletActive <= 1'b1;
				bulletX <= playerX + MUZZLE_X;
				bulletY <= PLAYER_Y - PLAYER_H;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/alienFormation.sv ====
`timescale 1ns/10ps
`default_nettype none

module alienFormation
	import invadersPkg::*;
(
	input wire clk,
	input wire spawnBullet,
	input wire gameTick,
	input wire [COORD_W-1:0] bulletX,
	input wire [COORD_W-1:0] bulletY,
	input wire bulletActive,
	output logic [COORD_W-1:0] formX,
	output logic [COORD_W-1:0] formY,
	output logic [NUM_ALIENS-1:0] aliveMask,
	output logic bulletHit,
	output logic aliensRemain,
	output logic gameOver,
	output logic [SCORE_W-1:0] score
);

	localparam int TICK_W = $clog2(STEP_TICKS);
	localparam int STEP_W = $clog2(MARCH_STEPS + 1);

	logic [TICK_W-1:0] tickCnt;
	logic [STEP_W-1:0] stepCnt;
	logic dirRight;
	logic [NUM_ALIENS-1:0][COORD_W-1:0] alienX;
	logic [NUM_ALIENS-1:0][COORD_W-1:0] alienY;
	logic [NUM_ALIENS-1:0] overlap;
	logic [NUM_ALIENS-1:0] killMask;
	logic [NUM_ALIENS-1:0] tooLow;

	////////////////////////////////////////////////////////////////////////////
	// per-alien origin, bullet overlap and landing check
	for (genvar i = 0; i < NUM_ALIENS; i++)
	begin : genAlien
		assign alienX[i] = formX + ALIEN_OFS_X[i];
		assign alienY[i] = formY + ALIEN_OFS_Y[i];
		assign overlap[i] = aliveMask[i] && bulletActive
			&& bulletX >= alienX[i] && bulletX <= alienX[i] + (ALIEN_W - 1'b1)
			&& bulletY >= alienY[i] && bulletY <= alienY[i] + HIT_DEPTH;
		assign tooLow[i] = aliveMask[i] && (alienY[i] > PLAYER_Y - 10'd8);
	end

	// isolate the lowest set bit, one kill per tick
	assign killMask = overlap & (~overlap + 1'b1);
	assign bulletHit = gameTick && !gameOver && (|overlap);
	assign aliensRemain = |aliveMask;

	always_ff @(posedge clk or posedge spawnBullet)
	begin
		if (spawnBullet)
		begin
			formX <= FORM_START_X;
			formY <= FORM_START_Y;
			dirRight <= 1'b1;
			tickCnt <= '0;
			stepCnt <= '0;
			aliveMask <= '1;
			score <= '0;
			gameOver <= 1'b0;
		end
		else if (gameTick && !gameOver)
		begin
			// march: sideways steps, then a drop and a turn
			if (tickCnt == TICK_W'(STEP_TICKS - 1))
			begin
				tickCnt <= '0;
				if (stepCnt == STEP_W'(MARCH_STEPS))
				begin
					formY <= formY + DROP_ROWS;
					dirRight <= !dirRight;
					stepCnt <= '0;
				end
				else
				begin
					formX <= dirRight ? formX + 1'b1 : formX - 1'b1;
					stepCnt <= stepCnt + 1'b1;
				end
			end
			else
				tickCnt <= tickCnt + 1'b1;

			if (bulletHit)
			begin
				aliveMask <= aliveMask & ~killMask;
				score <= score + SCORE_PER_HIT;
			end

			// sticky, cleared only by reset
			if (|tooLow)
				gameOver <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/pixelComposer.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixelComposer
	import invadersPkg::*;
(
	input wire [COORD_W-1:0] hPos,
	input wire [COORD_W-1:0] vPos,
	input wire [COORD_W-1:0] playerX,
	input wire [COORD_W-1:0] bulletX,
	input wire [COORD_W-1:0] bulletY,
	input wire bulletActive,
	input wire [COORD_W-1:0] formX,
	input wire [COORD_W-1:0] formY,
	input wire [NUM_ALIENS-1:0] aliveMask,
	input wire gameOver,
	output logic [COLOR_W-1:0] rgb
);

	logic [NUM_ALIENS-1:0] alienPix;
	logic activeArea;
	logic barPix;
	logic bulletPix;
	logic playerPix;

	////////////////////////////////////////////////////////////////////////////
	// object coverage at the current scan position
	for (genvar i = 0; i < NUM_ALIENS; i++)
	begin : genAlienPix
		logic [COORD_W-1:0] ax;
		logic [COORD_W-1:0] ay;

		assign ax = formX + ALIEN_OFS_X[i];
		assign ay = formY + ALIEN_OFS_Y[i];
		// box hangs upward from the origin row
		assign alienPix[i] = aliveMask[i]
			&& hPos >= ax && hPos <= ax + (ALIEN_W - 1'b1)
			&& vPos + (ALIEN_H - 1'b1) >= ay && vPos <= ay;
	end

	assign activeArea = hPos >= H_BACK && hPos < H_FRONT && vPos >= V_BACK && vPos < V_FRONT;
	assign barPix = hPos <= LEFT_BAR || hPos >= RIGHT_BAR;
	assign bulletPix = bulletActive
		&& hPos >= bulletX && hPos < bulletX + BULLET_W
		&& vPos + BULLET_H >= bulletY && vPos < bulletY;
	assign playerPix = hPos >= playerX && hPos < playerX + PLAYER_W
		&& vPos + PLAYER_H >= PLAYER_Y && vPos < PLAYER_Y;

	// priority from blanking down to background
	always_comb
	begin
		if (!activeArea)
			rgb = COL_BLACK;
		else if (gameOver)
			rgb = COL_RED;
		else if (|alienPix)
			rgb = COL_WHITE;
		else if (barPix)
			rgb = COL_BAR;
		else if (bulletPix)
			rgb = COL_YELLOW;
		else if (playerPix)
			rgb = COL_GREEN;
		else
			rgb = COL_BLACK;
	end

endmodule

`default_nettype wire

// ==== src/spaceInvaders.sv ====
`timescale 1ns/10ps
`default_nettype none

module spaceInvaders
	import invadersPkg::*;
(
	input wire clk,
	input wire spawnBullet,
	input wire pixelEn,
	input wire gameTick,
	input wire btnFire,
	input wire btnLeft,
	input wire btnRight,
	output wire hsync,
	output wire vsync,
	output wire [COLOR_W-1:0] rgb,
	output wire [SCORE_W-1:0] score
);

	// scan position
	wire [COORD_W-1:0] hPos;
	wire [COORD_W-1:0] vPos;

	// cannon and bullet
	wire [COORD_W-1:0] playerX;
	wire [COORD_W-1:0] bulletX;
	wire [COORD_W-1:0] bulletY;
	wire bulletActive;

	// formation state
	wire [COORD_W-1:0] formX;
	wire [COORD_W-1:0] formY;
	wire [NUM_ALIENS-1:0] aliveMask;
	wire bulletHit;
	wire aliensRemain;
	wire gameOver;

	////////////////////////////////////////////////////////////////////////////
	scanTiming scanTiming_inst (
		.clk(clk),
		.spawnBullet(spawnBullet),
		.pixelEn(pixelEn),
		.hPos(hPos),
		.vPos(vPos),
		.hsync(hsync),
		.vsync(vsync)
	);

	playerCannon playerCannon_inst (
		.clk(clk),
		.spawnBullet(spawnBullet),
		.gameTick(gameTick),
		.btnFire(btnFire),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.bulletHit(bulletHit),
		.aliensRemain(aliensRemain),
		.gameOver(gameOver),
		.playerX(playerX),
		.bulletX(bulletX),
		.bulletY(bulletY),
		.bulletActive(bulletActive)
	);

	alienFormation alienFormation_inst (
		.clk(clk),
		.spawnBullet(spawnBullet),
		.gameTick(gameTick),
		.bulletX(bulletX),
		.bulletY(bulletY),
		.bulletActive(bulletActive),
		.formX(formX),
		.formY(formY),
		.aliveMask(aliveMask),
		.bulletHit(bulletHit),
		.aliensRemain(aliensRemain),
		.gameOver(gameOver),
		.score(score)
	);

	// colour follows the counters in the same cycle
	pixelComposer pixelComposer_inst (
		.hPos(hPos),
		.vPos(vPos),
		.playerX(playerX),
		.bulletX(bulletX),
		.bulletY(bulletY),
		.bulletActive(bulletActive),
		.formX(formX),
		.formY(formY),
		.aliveMask(aliveMask),
		.gameOver(gameOver),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// ==== tests/spaceInvaders_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module spaceInvaders_assertions
	import invadersPkg::*;
(
	input wire clk,
	input wire spawnBullet,
	input wire [COORD_W-1:0] hPos,
	input wire hsync,
	input wire gameOver,
	input wire [SCORE_W-1:0] score
);

	localparam logic [SCORE_W-1:0] MAX_SCORE = SCORE_W'(int'(SCORE_PER_HIT) * NUM_ALIENS);

	// line pulse starts at the counter wrap
	hsyncFall: assert property (@(posedge clk) disable iff (spawnBullet)
		$fell(hsync) |-> $past(hPos) == H_TOTAL - 1'b1)
		else $error("hsync fell away from the line wrap");

	// and ends once the counter leaves the pulse
	hsyncRise: assert property (@(posedge clk) disable iff (spawnBullet)
		$rose(hsync) |-> $past(hPos) == H_PULSE - 1'b1)
		else $error("hsync rose away from the end of the pulse");

	// game over is sticky until reset
	gameOverSticky: assert property (@(posedge clk) disable iff (spawnBullet)
		gameOver |=> gameOver)
		else $error("gameOver fell without reset");

	scoreBound: assert property (@(posedge clk) disable iff (spawnBullet)
		score <= MAX_SCORE)
		else $error("score above the five-kill maximum");

endmodule

`default_nettype wire

// ==== tests/spaceInvadersTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module spaceInvadersTb
	import invadersPkg::*;
();

	localparam int MAX_ROWS = 40;
	localparam int FRAME_CYCLES = 800 * 521;

	logic clk;
	logic spawnBullet;
	logic pixelEn;
	logic gameTick;
	logic btnFire;
	logic btnLeft;
	logic btnRight;
	wire hsync;
	wire vsync;
	wire [COLOR_W-1:0] rgb;
	wire [SCORE_W-1:0] score;

	// scan position as the testbench expects it
	int hTrack;
	int vTrack;
	int limitCycles;

	// stimulus and expected results, one entry per step
	int numRows;
	string rowName [MAX_ROWS];
	logic rowLeft [MAX_ROWS];
	logic rowRight [MAX_ROWS];
	logic rowFire [MAX_ROWS];
	int rowTicks [MAX_ROWS];
	int rowH [MAX_ROWS];
	int rowV [MAX_ROWS];
	logic [COLOR_W-1:0] rowRgb [MAX_ROWS];
	logic [SCORE_W-1:0] rowScore [MAX_ROWS];

	spaceInvaders spaceInvaders_inst (
		.clk(clk),
		.spawnBullet(spawnBullet),
		.pixelEn(pixelEn),
		.gameTick(gameTick),
		.btnFire(btnFire),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.hsync(hsync),
		.vsync(vsync),
		.rgb(rgb),
		.score(score)
	);

	bind spaceInvaders spaceInvaders_assertions spaceInvaders_assertions_inst (
		.clk(clk),
		.spawnBullet(spawnBullet),
		.hPos(hPos),
		.hsync(hsync),
		.gameOver(gameOver),
		.score(score)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	task automatic addRow(input string name, input logic left, input logic right,
		input logic fire, input int ticks, input int h, input int v,
		input logic [COLOR_W-1:0] color, input logic [SCORE_W-1:0] points);
		rowName[numRows] = name;
		rowLeft[numRows] = left;
		rowRight[numRows] = right;
		rowFire[numRows] = fire;
		rowTicks[numRows] = ticks;
		rowH[numRows] = h;
		rowV[numRows] = v;
		rowRgb[numRows] = color;
		rowScore[numRows] = points;
		numRows++;
	endtask

	// one clock, inputs change 1 ns after the edge
	task automatic stepCycle();
		@(posedge clk);
		#1;
		if (hTrack == int'(H_TOTAL) - 1)
		begin
			hTrack = 0;
			vTrack = (vTrack == int'(V_TOTAL) - 1) ? 0 : vTrack + 1;
		end
		else
			hTrack = hTrack + 1;
	endtask

	task automatic applyTicks(input int ticks);
		for (int i = 0; i < ticks; i++)
		begin
			gameTick = 1'b1;
			stepCycle();
			gameTick = 1'b0;
			stepCycle();
		end
	endtask

	task automatic waitForScan(input int h, input int v);
		while (hTrack != h || vTrack != v)
			stepCycle();
	endtask

	task automatic checkColor(input string name, input logic [COLOR_W-1:0] expected,
		input logic [COLOR_W-1:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected rgb %h, actual %h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "rgb mismatch");
		end
	endtask

	task automatic checkScore(input string name, input logic [SCORE_W-1:0] expected,
		input logic [SCORE_W-1:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected score %0d, actual %0d", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "score mismatch");
		end
	endtask

	task automatic checkSync(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s at (%0d,%0d): expected %b, actual %b", name, hTrack, vTrack,
				expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "sync mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// formation steps every 4 ticks, player box rows 434..440
	task automatic buildTable();
		addRow("initBar", 1'b0, 1'b0, 1'b0, 0, 200, 100, COL_BAR, 6'd0);
		addRow("initAlien0", 1'b0, 1'b0, 1'b0, 0, 349, 248, COL_WHITE, 6'd0);
		addRow("initAlien1", 1'b0, 1'b0, 1'b0, 0, 389, 248, COL_WHITE, 6'd0);
		addRow("initAlien2", 1'b0, 1'b0, 1'b0, 0, 429, 248, COL_WHITE, 6'd0);
		addRow("initAlien3", 1'b0, 1'b0, 1'b0, 0, 349, 278, COL_WHITE, 6'd0);
		addRow("initAlien4", 1'b0, 1'b0, 1'b0, 0, 429, 278, COL_WHITE, 6'd0);
		addRow("initPlayer", 1'b0, 1'b0, 1'b0, 0, 470, 437, COL_GREEN, 6'd0);
		addRow("initBlank", 1'b0, 1'b0, 1'b0, 0, 100, 437, COL_BLACK, 6'd0);
		addRow("initEmpty", 1'b0, 1'b0, 1'b0, 0, 500, 100, COL_BLACK, 6'd0);
		// player walks left to 444, right to 454, then stops at the bar
		addRow("leftMove", 1'b1, 1'b0, 1'b0, 20, 444, 437, COL_GREEN, 6'd0);
		addRow("leftEdge", 1'b0, 1'b0, 1'b0, 0, 462, 437, COL_BLACK, 6'd0);
		addRow("rightMove", 1'b0, 1'b1, 1'b0, 10, 471, 437, COL_GREEN, 6'd0);
		addRow("rightEdge", 1'b0, 1'b0, 1'b0, 0, 472, 437, COL_BLACK, 6'd0);
		addRow("leftStop", 1'b1, 1'b0, 1'b0, 130, 344, 437, COL_BAR, 6'd0);
		addRow("stopInside", 1'b0, 1'b0, 1'b0, 0, 345, 437, COL_GREEN, 6'd0);
		addRow("stopEdge", 1'b0, 1'b0, 1'b0, 0, 362, 437, COL_BLACK, 6'd0);
		addRow("rightBack", 1'b0, 1'b1, 1'b0, 160, 521, 437, COL_GREEN, 6'd0);
		// bullet spawns at column 513, row 434
		addRow("fire", 1'b0, 1'b0, 1'b1, 1, 513, 424, COL_YELLOW, 6'd0);
		addRow("fireBottom", 1'b0, 1'b0, 1'b0, 0, 514, 433, COL_YELLOW, 6'd0);
		addRow("fireMuzzle", 1'b0, 1'b0, 1'b0, 0, 513, 434, COL_GREEN, 6'd0);
		addRow("rise", 1'b0, 1'b0, 1'b0, 40, 513, 384, COL_YELLOW, 6'd0);
		addRow("riseAbove", 1'b0, 1'b0, 1'b0, 0, 513, 383, COL_BLACK, 6'd0);
		addRow("riseAlien1", 1'b0, 1'b0, 1'b0, 0, 479, 248, COL_WHITE, 6'd0);
		// tick 497 meets alien 1 at formX 468
		addRow("hitAlien1", 1'b0, 1'b0, 1'b0, 136, 513, 248, COL_BLACK, 6'd10);
		addRow("hitAlien0", 1'b0, 1'b0, 1'b0, 0, 473, 248, COL_WHITE, 6'd10);
		addRow("hitAlien2", 1'b0, 1'b0, 1'b0, 0, 553, 248, COL_WHITE, 6'd10);
		// sixteenth drop at tick 9280 puts the lower row at 441
		addRow("lowestRow", 1'b0, 1'b0, 1'b0, 8783, 349, 438, COL_WHITE, 6'd10);
		addRow("gameOver", 1'b0, 1'b0, 1'b0, 1, 349, 438, COL_RED, 6'd10);
		addRow("overBar", 1'b0, 1'b0, 1'b0, 0, 200, 100, COL_RED, 6'd10);
		addRow("overBlank", 1'b0, 1'b0, 1'b0, 0, 100, 300, COL_BLACK, 6'd10);
		addRow("overCorner", 1'b0, 1'b0, 1'b0, 0, 783, 510, COL_RED, 6'd10);
		addRow("frozen", 1'b1, 1'b0, 1'b1, 50, 513, 248, COL_RED, 6'd10);
	endtask

	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		int totalTicks;

		spawnBullet = 1'b1;
		pixelEn = 1'b1;
		gameTick = 1'b0;
		btnFire = 1'b0;
		btnLeft = 1'b0;
		btnRight = 1'b0;
		hTrack = 0;
		vTrack = 0;
		numRows = 0;
		limitCycles = 0;
		buildTable();
		totalTicks = 0;
		for (int i = 0; i < numRows; i++)
			totalTicks += rowTicks[i];
		// two frames per row plus the sync frame
		limitCycles = totalTicks * 2 + numRows * 2 * FRAME_CYCLES + 2 * FRAME_CYCLES;

		repeat (8) @(posedge clk);
		#1;
		spawnBullet = 1'b0;

		// sync pulses over one whole frame
		for (int n = 0; n < FRAME_CYCLES; n++)
		begin
			checkSync("hsync", hTrack >= int'(H_PULSE), hsync);
			checkSync("vsync", vTrack >= int'(V_PULSE), vsync);
			stepCycle();
		end

		for (int r = 0; r < numRows; r++)
		begin
			btnLeft = rowLeft[r];
			btnRight = rowRight[r];
			btnFire = rowFire[r];
			applyTicks(rowTicks[r]);
			btnLeft = 1'b0;
			btnRight = 1'b0;
			btnFire = 1'b0;
			waitForScan(rowH[r], rowV[r]);
			checkColor(rowName[r], rowRgb[r], rgb);
			checkScore(rowName[r], rowScore[r], score);
		end

		$display("NO ERRORS");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("watchdog expired: the run hung after %0d cycles", limitCycles);
		$display("ERRORS FOUND");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// ==== src.f ====
src/invadersPkg.sv
src/scanTiming.sv
src/playerCannon.sv
src/alienFormation.sv
src/pixelComposer.sv
src/spaceInvaders.sv
tests/spaceInvaders_assertions.sv
tests/spaceInvadersTb.sv

// ==== Makefile ====
SIM := obj_dir/VspaceInvadersTb
SOURCES := $(shell cat src.f)

.PHONY: all run clean

all: run

$(SIM): src.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module spaceInvadersTb -f src.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
